// ==== verilog/predecoderPkg.sv ====
package predecoderPkg;

    // AXI4-Lite read port sizing
    localparam int fetchDataWidth = 32;
    localparam int fetchAddrWidth = 16;

    // command codes, one per mnemonic
    localparam logic [5:0]
        cmdBrk = 6'd0,  cmdJsr = 6'd1,  cmdRti = 6'd2,  cmdRts = 6'd3,
        cmdLdy = 6'd4,  cmdCpy = 6'd5,  cmdCpx = 6'd6,  cmdBit = 6'd7,
        cmdSty = 6'd8,  cmdPhp = 6'd9,  cmdPlp = 6'd10, cmdPha = 6'd11,
        cmdPla = 6'd12, cmdDey = 6'd13, cmdTay = 6'd14, cmdIny = 6'd15,
        cmdInx = 6'd16, cmdJmp = 6'd17, cmdBpl = 6'd18, cmdBmi = 6'd19,
        cmdBvc = 6'd20, cmdBvs = 6'd21, cmdBcc = 6'd22, cmdBcs = 6'd23,
        cmdBne = 6'd24, cmdBeq = 6'd25, cmdClc = 6'd26, cmdSec = 6'd27,
        cmdCli = 6'd28, cmdSei = 6'd29, cmdTya = 6'd30, cmdClv = 6'd31,
        cmdCld = 6'd32, cmdSed = 6'd33, cmdOra = 6'd34, cmdAnd = 6'd35,
        cmdEor = 6'd36, cmdAdc = 6'd37, cmdSta = 6'd38, cmdLda = 6'd39,
        cmdCmp = 6'd40, cmdSbc = 6'd41, cmdLdx = 6'd42, cmdAsl = 6'd43,
        cmdRol = 6'd44, cmdLsr = 6'd45, cmdRor = 6'd46, cmdStx = 6'd47,
        cmdDec = 6'd48, cmdInc = 6'd49, cmdTxa = 6'd50, cmdTax = 6'd51,
        cmdDex = 6'd52, cmdNop = 6'd53, cmdTxs = 6'd54, cmdTsx = 6'd55,
        cmdAslA = 6'd56, cmdRolA = 6'd57, cmdLsrA = 6'd58, cmdRorA = 6'd59,
        cmdIll = 6'd60; // holes and column 3

    // addressing modes
    localparam logic [3:0]
        modeImpl = 4'd0,  modeAcc = 4'd1,   modeImm = 4'd2,   modeZpg = 4'd3,
        modeZpgX = 4'd4,  modeZpgY = 4'd5,  modeAbs = 4'd6,   modeAbsX = 4'd7,
        modeAbsY = 4'd8,  modeInd = 4'd9,   modeXInd = 4'd10, modeIndY = 4'd11,
        modeRel = 4'd12;

    // opcode as aaabbbcc
    typedef struct packed {
        logic [2:0] grpA; // operation
        logic [2:0] grpB; // mode row
        logic [1:0] grpC; // column
    } opcodeFields;

    typedef union packed {
        logic [7:0]  whole;
        opcodeFields fields;
    } opcodeWord;

    // operand bytes per mode, indexed by mode code
    localparam logic [1:0] operandCount [16] = '{
        2'd0, 2'd0, 2'd1, 2'd1,  // impl acc imm zpg
        2'd1, 2'd1, 2'd2, 2'd2,  // zpgX zpgY abs absX
        2'd2, 2'd2, 2'd1, 2'd1,  // absY ind xInd indY
        2'd1, 2'd0, 2'd0, 2'd0   // rel, unused codes
    };

endpackage

// ==== verilog/decoder.sv ====
`timescale 1ns/1ns
module decoder import predecoderPkg::*; (
    input  opcodeWord  opcode,
    output logic [5:0] cmd,
    output logic [3:0] mode
);

    logic [2:0] grpA;
    logic [2:0] grpB;

    assign grpA = opcode.fields.grpA;
    assign grpB = opcode.fields.grpB;

    always_comb begin
        cmd  = cmdIll;
        mode = modeImpl;
        case (opcode.fields.grpC)
            2'b00: begin
                case (grpB)
                    3'b000: begin
                        mode = grpA[2] ? modeImm : ((grpA == 3'b001) ? modeAbs : modeImpl);
                        case (grpA)
                            3'b000:  cmd = cmdBrk;
                            3'b001:  cmd = cmdJsr;
                            3'b010:  cmd = cmdRti;
                            3'b011:  cmd = cmdRts;
                            3'b101:  cmd = cmdLdy;
                            3'b110:  cmd = cmdCpy;
                            3'b111:  cmd = cmdCpx;
                            default: cmd = cmdIll; // 0x80
                        endcase
                    end
                    3'b001, 3'b011: begin // zero page and absolute rows
                        mode = grpB[1] ? modeAbs : modeZpg;
                        case (grpA)
                            3'b001:  cmd = cmdBit;
                            3'b010:  cmd = grpB[1] ? cmdJmp : cmdIll;
                            3'b011: begin
                                cmd  = grpB[1] ? cmdJmp : cmdIll;
                                mode = modeInd; // jmp (abs)
                            end
                            3'b100:  cmd = cmdSty;
                            3'b101:  cmd = cmdLdy;
                            3'b110:  cmd = cmdCpy;
                            3'b111:  cmd = cmdCpx;
                            default: cmd = cmdIll;
                        endcase
                    end
                    3'b010: begin
                        case (grpA)
                            3'b000:  cmd = cmdPhp;
                            3'b001:  cmd = cmdPlp;
                            3'b010:  cmd = cmdPha;
                            3'b011:  cmd = cmdPla;
                            3'b100:  cmd = cmdDey;
                            3'b101:  cmd = cmdTay;
                            3'b110:  cmd = cmdIny;
                            default: cmd = cmdInx;
                        endcase
                    end
                    3'b100: begin
                        mode = modeRel; // branches
                        case (grpA)
                            3'b000:  cmd = cmdBpl;
                            3'b001:  cmd = cmdBmi;
                            3'b010:  cmd = cmdBvc;
                            3'b011:  cmd = cmdBvs;
                            3'b100:  cmd = cmdBcc;
                            3'b101:  cmd = cmdBcs;
                            3'b110:  cmd = cmdBne;
                            default: cmd = cmdBeq;
                        endcase
                    end
                    3'b101: begin
                        mode = modeZpgX;
                        if (grpA == 3'b100) cmd = cmdSty;
                        if (grpA == 3'b101) cmd = cmdLdy;
                    end
                    3'b110: begin
                        case (grpA)
                            3'b000:  cmd = cmdClc;
                            3'b001:  cmd = cmdSec;
                            3'b010:  cmd = cmdCli;
                            3'b011:  cmd = cmdSei;
                            3'b100:  cmd = cmdTya;
                            3'b101:  cmd = cmdClv;
                            3'b110:  cmd = cmdCld;
                            default: cmd = cmdSed;
                        endcase
                    end
                    default: begin
                        mode = modeAbsX;
                        if (grpA == 3'b101) cmd = cmdLdy;
                    end
                endcase
            end
            2'b01: begin // alu group, mode purely by row
                case (grpB)
                    3'b000:  mode = modeXInd;
                    3'b001:  mode = modeZpg;
                    3'b010:  mode = modeImm;
                    3'b011:  mode = modeAbs;
                    3'b100:  mode = modeIndY;
                    3'b101:  mode = modeZpgX;
                    3'b110:  mode = modeAbsY;
                    default: mode = modeAbsX;
                endcase
                case (grpA)
                    3'b000:  cmd = cmdOra;
                    3'b001:  cmd = cmdAnd;
                    3'b010:  cmd = cmdEor;
                    3'b011:  cmd = cmdAdc;
                    3'b100:  cmd = cmdSta;
                    3'b101:  cmd = cmdLda;
                    3'b110:  cmd = cmdCmp;
                    default: cmd = cmdSbc;
                endcase
                if (opcode.whole == 8'h89) cmd = cmdIll; // no sta immediate
            end
            2'b10: begin
                case (grpB)
                    3'b000: begin
                        mode = modeImm;
                        if (grpA == 3'b101) cmd = cmdLdx;
                    end
                    3'b010: begin
                        mode = grpA[2] ? modeImpl : modeAcc;
                        case (grpA)
                            3'b000:  cmd = cmdAslA;
                            3'b001:  cmd = cmdRolA;
                            3'b010:  cmd = cmdLsrA;
                            3'b011:  cmd = cmdRorA;
                            3'b100:  cmd = cmdTxa;
                            3'b101:  cmd = cmdTax;
                            3'b110:  cmd = cmdDex;
                            default: cmd = cmdNop;
                        endcase
                    end
                    3'b100: cmd = cmdIll;
                    3'b110: begin
                        if (grpA == 3'b100) cmd = cmdTxs;
                        if (grpA == 3'b101) cmd = cmdTsx;
                    end
                    default: begin // odd rows, shifts and x moves
                        case (grpB)
                            3'b001:  mode = modeZpg;
                            3'b011:  mode = modeAbs;
                            3'b101:  mode = (grpA[2:1] == 2'b10) ? modeZpgY : modeZpgX;
                            default: mode = (grpA == 3'b101) ? modeAbsY : modeAbsX;
                        endcase
                        case (grpA)
                            3'b000:  cmd = cmdAsl;
                            3'b001:  cmd = cmdRol;
                            3'b010:  cmd = cmdLsr;
                            3'b011:  cmd = cmdRor;
                            3'b100:  cmd = cmdStx;
                            3'b101:  cmd = cmdLdx;
                            3'b110:  cmd = cmdDec;
                            default: cmd = cmdInc;
                        endcase
                        if (opcode.whole == 8'h9e) cmd = cmdIll; // no stx abs,x
                    end
                endcase
            end
            default: cmd = cmdIll;
        endcase
        if (cmd == cmdIll) mode = modeImpl; // illegal is always one byte
    end

endmodule

// ==== verilog/fetchStage.sv ====
`timescale 1ns/1ns
module fetchStage import predecoderPkg::*; (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      start,
    input  logic [fetchAddrWidth-1:0] startPc,
    output logic                      arValid,
    input  logic                      arReady,
    output logic [fetchAddrWidth-1:0] arAddr,
    input  logic                      rValid,
    output logic                      rReady,
    input  logic [fetchDataWidth-1:0] rData,
    input  logic [1:0]                rResp,
    output logic                      busError,
    output logic                      byteValid,
    input  logic                      byteReady,
    output logic [7:0]                byteData,
    output logic [fetchAddrWidth-1:0] byteAddr
);

    logic [fetchDataWidth-1:0] wordBuf;
    logic                      bufValid;
    logic [1:0]                byteIdx;
    logic [fetchAddrWidth-1:0] wordPtr;  // address of the buffered word
    logic                      running;
    logic                      dropResp; // in-flight read predates the last start
    logic                      arFire;
    logic                      rFire;
    logic                      byteFire;

    assign arFire   = arValid && arReady;
    assign rFire    = rValid && rReady;
    assign byteFire = byteValid && byteReady;

    assign byteValid = bufValid;
    assign byteData  = wordBuf[8*byteIdx +: 8]; // little endian within the word
    assign byteAddr  = {wordPtr[fetchAddrWidth-1:2], byteIdx};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            arValid  <= 1'b0;
            arAddr   <= '0;
            rReady   <= 1'b0;
            bufValid <= 1'b0;
            byteIdx  <= 2'd0;
            wordPtr  <= '0;
            running  <= 1'b0;
            dropResp <= 1'b0;
            busError <= 1'b0;
        end else if (start) begin
            wordPtr  <= {startPc[fetchAddrWidth-1:2], 2'b00};
            byteIdx  <= startPc[1:0]; // skip bytes below the start offset
            bufValid <= 1'b0;
            busError <= 1'b0;
            running  <= 1'b1;
            if (arFire) begin
                arValid  <= 1'b0;
                rReady   <= 1'b1;
                dropResp <= 1'b1;
            end else if (arValid || (rReady && !rValid)) begin
                dropResp <= 1'b1; // let it finish, then refetch
            end else begin
                rReady   <= 1'b0;
                arValid  <= 1'b1;
                arAddr   <= {startPc[fetchAddrWidth-1:2], 2'b00};
                dropResp <= 1'b0;
            end
        end else begin
            if (arFire) begin
                arValid <= 1'b0;
                rReady  <= 1'b1;
            end
            if (rFire) begin
                rReady <= 1'b0;
                if (dropResp) begin
                    dropResp <= 1'b0;
                end else if (rResp != 2'b00) begin
                    busError <= 1'b1; // stop until next start
                    running  <= 1'b0;
                end else begin
                    bufValid <= 1'b1;
                end
            end
            if (byteFire) begin
                byteIdx <= byteIdx + 2'd1;
                if (byteIdx == 2'd3) begin
                    bufValid <= 1'b0;
                    wordPtr  <= wordPtr + fetchAddrWidth'(4);
                end
            end
            if (running && !bufValid && !arValid && !rReady) begin
                arValid <= 1'b1;
                arAddr  <= wordPtr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rFire) wordBuf <= rData;
    end

endmodule

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ns
module decodeStage import predecoderPkg::*; (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      start,
    input  logic                      byteValid,
    output logic                      byteReady,
    input  logic [7:0]                byteData,
    input  logic [fetchAddrWidth-1:0] byteAddr,
    output logic                      opValid,
    input  logic                      opReady,
    output logic [5:0]                opCmd,
    output logic [3:0]                opMode,
    output logic [1:0]                opCount,
    output logic [fetchAddrWidth-1:0] opAddr,
    output logic                      fwdValid,
    input  logic                      fwdReady,
    output logic [7:0]                fwdData
);

    opcodeWord  opcode;
    logic [5:0] decCmd;
    logic [3:0] decMode;
    logic [1:0] remain; // operand bytes still to forward
    logic       opcodeFire;

    assign opcode.whole = byteData;

    decoder decoder_inst (
        .opcode(opcode),
        .cmd   (decCmd),
        .mode  (decMode)
    );

    // zero remain means the next byte is an opcode
    assign byteReady  = (remain == 2'd0) ? (!opValid || opReady) : fwdReady;
    assign fwdValid   = byteValid && (remain != 2'd0);
    assign fwdData    = byteData;
    assign opcodeFire = byteValid && byteReady && (remain == 2'd0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            opValid <= 1'b0;
            remain  <= 2'd0;
        end else if (start) begin
            opValid <= 1'b0;
            remain  <= 2'd0;
        end else begin
            if (opValid && opReady) opValid <= 1'b0;
            if (opcodeFire) begin
                opValid <= 1'b1;
                remain  <= operandCount[decMode];
            end else if (fwdValid && fwdReady) begin
                remain <= remain - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (opcodeFire) begin
            opCmd   <= decCmd;
            opMode  <= decMode;
            opCount <= operandCount[decMode];
            opAddr  <= byteAddr; // pc of the instruction
        end
    end

endmodule

// ==== verilog/operandStage.sv ====
`timescale 1ns/1ns
module operandStage import predecoderPkg::*; (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      start,
    input  logic                      opValid,
    output logic                      opReady,
    input  logic [5:0]                opCmd,
    input  logic [3:0]                opMode,
    input  logic [1:0]                opCount,
    input  logic [fetchAddrWidth-1:0] opAddr,
    input  logic                      fwdValid,
    output logic                      fwdReady,
    input  logic [7:0]                fwdData,
    output logic                      instValid,
    input  logic                      instReady,
    output logic [fetchAddrWidth-1:0] instPc,
    output logic [5:0]                instCmd,
    output logic [3:0]                instMode,
    output logic [15:0]               instOperand
);

    logic       busy;   // header held, operands pending
    logic [1:0] need;
    logic       loDone; // low operand byte filled
    logic       headFire;
    logic       byteFire;

    // a new header may overwrite the output only once it is gone
    assign opReady  = !busy && (!instValid || instReady);
    assign fwdReady = busy;
    assign headFire = opValid && opReady;
    assign byteFire = fwdValid && fwdReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instValid <= 1'b0;
            busy      <= 1'b0;
            need      <= 2'd0;
            loDone    <= 1'b0;
        end else if (start) begin
            instValid <= 1'b0;
            busy      <= 1'b0;
            need      <= 2'd0;
            loDone    <= 1'b0;
        end else begin
            if (instValid && instReady) instValid <= 1'b0;
            if (headFire) begin
                need   <= opCount;
                loDone <= 1'b0;
                if (opCount == 2'd0) instValid <= 1'b1;
                else busy <= 1'b1;
            end
            if (byteFire) begin
                need   <= need - 2'd1;
                loDone <= 1'b1;
                if (need == 2'd1) begin // last operand byte
                    busy      <= 1'b0;
                    instValid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (headFire) begin
            instPc      <= opAddr;
            instCmd     <= opCmd;
            instMode    <= opMode;
            instOperand <= '0;
        end
        if (byteFire) begin
            if (loDone) instOperand[15:8] <= fwdData;
            else instOperand[7:0] <= fwdData;
        end
    end

endmodule

// ==== verilog/instructionPredecoder.sv ====
`timescale 1ns/1ns
module instructionPredecoder import predecoderPkg::*; (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      start,
    input  logic [fetchAddrWidth-1:0] startPc,
    output logic                      arValid,
    input  logic                      arReady,
    output logic [fetchAddrWidth-1:0] arAddr,
    input  logic                      rValid,
    output logic                      rReady,
    input  logic [fetchDataWidth-1:0] rData,
    input  logic [1:0]                rResp,
    output logic                      busError,
    output logic                      instValid,
    input  logic                      instReady,
    output logic [fetchAddrWidth-1:0] instPc,
    output logic [5:0]                instCmd,
    output logic [3:0]                instMode,
    output logic [15:0]               instOperand
);

    // fetch to decode
    logic                      byteValid;
    logic                      byteReady;
    logic [7:0]                byteData;
    logic [fetchAddrWidth-1:0] byteAddr;

    // decode to operand, header plus forwarded bytes
    logic                      opValid;
    logic                      opReady;
    logic [5:0]                opCmd;
    logic [3:0]                opMode;
    logic [1:0]                opCount;
    logic [fetchAddrWidth-1:0] opAddr;
    logic                      fwdValid;
    logic                      fwdReady;
    logic [7:0]                fwdData;

    fetchStage fetchStage_inst (.*);

    decodeStage decodeStage_inst (.*);

    operandStage operandStage_inst (.*);

endmodule

// ==== tb/predecoder_assertions.sv ====
`timescale 1ns/1ns
module predecoderAssertions import predecoderPkg::*; (
    input logic                      clk,
    input logic                      arstN,
    input logic                      start,
    input logic [fetchAddrWidth-1:0] startPc,
    input logic                      arValid,
    input logic                      arReady,
    input logic [fetchAddrWidth-1:0] arAddr,
    input logic                      rValid,
    input logic                      rReady,
    input logic [fetchDataWidth-1:0] rData,
    input logic [1:0]                rResp,
    input logic                      busError,
    input logic                      instValid,
    input logic                      instReady,
    input logic [fetchAddrWidth-1:0] instPc,
    input logic [5:0]                instCmd,
    input logic [3:0]                instMode,
    input logic [15:0]               instOperand
);

    int errCount = 0; // failed checks so far

    logic [7:0]  shadow [256]; // copy of every word read back with OKAY
    logic [7:0]  reqAddr;
    logic        outstanding;
    logic [15:0] expPc;
    logic [7:0]  opByte;
    logic [1:0]  cnt;
    logic [15:0] expOperand;
    logic [10:0] refDec;

    // {known, cmd, mode} for the opcodes the directed program uses
    function automatic logic [10:0] refDecode(input logic [7:0] op);
        if (op[1:0] == 2'b11) return {1'b1, cmdIll, modeImpl};
        case (op)
            8'ha9:   return {1'b1, cmdLda, modeImm};
            8'h6c:   return {1'b1, cmdJmp, modeInd};
            8'h96:   return {1'b1, cmdStx, modeZpgY};
            8'h0a:   return {1'b1, cmdAslA, modeAcc};
            8'h06:   return {1'b1, cmdAsl, modeZpg};
            8'hd0:   return {1'b1, cmdBne, modeRel};
            default: return 11'd0;
        endcase
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outstanding <= 1'b0;
            reqAddr     <= 8'h00;
            expPc       <= 16'h0000;
        end else begin
            if (arValid && arReady) begin
                outstanding <= 1'b1;
                reqAddr     <= arAddr[7:0];
            end
            if (rValid && rReady) outstanding <= 1'b0;
            if (start) expPc <= startPc;
            else if (instValid && instReady) expPc <= instPc + 16'd1 + 16'(operandCount[instMode]);
        end
    end

    always_ff @(posedge clk) begin
        if (rValid && rReady && rResp == 2'b00) begin
            shadow[reqAddr]         <= rData[7:0];
            shadow[reqAddr + 8'd1]  <= rData[15:8];
            shadow[reqAddr + 8'd2]  <= rData[23:16];
            shadow[reqAddr + 8'd3]  <= rData[31:24];
        end
    end

    assign opByte     = shadow[instPc[7:0]];
    assign cnt        = operandCount[instMode];
    assign refDec     = refDecode(opByte);
    assign expOperand = {(cnt == 2'd2) ? shadow[instPc[7:0] + 8'd2] : 8'h00,
                         (cnt != 2'd0) ? shadow[instPc[7:0] + 8'd1] : 8'h00};

    resetQuietChk: assert property (@(posedge clk)
        !arstN |-> !arValid && !rReady && !instValid && !busError)
        else begin errCount++; $error("outputs not low while reset is held"); end

    pcChainChk: assert property (@(posedge clk) disable iff (!arstN)
        instValid && !start |-> instPc == expPc)
        else begin errCount++; $error("[FAIL] instPc exp %h got %h", expPc, instPc); end

    cmdChk: assert property (@(posedge clk) disable iff (!arstN)
        instValid && !start && refDec[10] |-> instCmd == refDec[9:4])
        else begin errCount++; $error("[FAIL] instCmd exp %h got %h", refDec[9:4], instCmd); end

    modeChk: assert property (@(posedge clk) disable iff (!arstN)
        instValid && !start && refDec[10] |-> instMode == refDec[3:0])
        else begin errCount++; $error("[FAIL] instMode exp %h got %h", refDec[3:0], instMode); end

    operandChk: assert property (@(posedge clk) disable iff (!arstN)
        instValid && !start |-> instOperand == expOperand)
        else begin
            errCount++;
            $error("[FAIL] instOperand exp %h got %h", expOperand, instOperand);
        end

    // stalled output must not move
    holdChk: assert property (@(posedge clk) disable iff (!arstN)
        instValid && !instReady && !start |=> instValid && $stable(instPc)
            && $stable(instCmd) && $stable(instMode) && $stable(instOperand))
        else begin errCount++; $error("instruction output changed while stalled"); end

    arAlignChk: assert property (@(posedge clk) disable iff (!arstN)
        arValid |-> arAddr[1:0] == 2'b00)
        else begin errCount++; $error("[FAIL] arAddr exp %h got %h", arAddr & 16'hfffc, arAddr); end

    arHoldChk: assert property (@(posedge clk) disable iff (!arstN)
        arValid && !arReady |=> arValid && $stable(arAddr))
        else begin errCount++; $error("read request dropped or moved before arReady"); end

    oneReadChk: assert property (@(posedge clk) disable iff (!arstN)
        outstanding |-> !arValid)
        else begin errCount++; $error("second read issued while one is outstanding"); end

    errSetChk: assert property (@(posedge clk) disable iff (!arstN)
        rValid && rReady && rResp != 2'b00 && !start |=> busError)
        else begin errCount++; $error("error response did not set busError"); end

    errStopChk: assert property (@(posedge clk) disable iff (!arstN)
        busError && !start |-> !arValid)
        else begin errCount++; $error("read issued after a bus error"); end

    restartChk: assert property (@(posedge clk) disable iff (!arstN)
        start && busError |=> !busError && arValid && arAddr == ($past(startPc) & 16'hfffc))
        else begin errCount++; $error("start did not clear the bus error and refetch"); end

endmodule

bind instructionPredecoder predecoderAssertions predecoderAssertions_inst (.*);

// ==== tb/predecoderTb.sv ====
`timescale 1ns/1ns
module predecoderTb import predecoderPkg::*; ();

    localparam logic [7:0] errWord    = 8'hf0; // this word answers SLVERR
    localparam int         instPerRun = 12;
    localparam int         progBytes  = 3 * 3 * instPerRun + 64; // three runs plus error path
    localparam int         cycleLimit = 40 * progBytes;

    // lda #, jmp (ind), stx zpg,y, asl a, asl zpg, bne, column 3
    localparam logic [7:0] directed [13] = '{
        8'ha9, 8'h12, 8'h6c, 8'h34, 8'h56, 8'h96, 8'h78,
        8'h0a, 8'h06, 8'h9a, 8'hd0, 8'hfe, 8'h03
    };

    logic                      clk = 1'b0;
    logic                      arstN;
    logic                      start;
    logic [fetchAddrWidth-1:0] startPc;
    logic                      arValid;
    logic                      arReady = 1'b0;
    logic [fetchAddrWidth-1:0] arAddr;
    logic                      rValid = 1'b0;
    logic                      rReady;
    logic [fetchDataWidth-1:0] rData = '0;
    logic [1:0]                rResp = 2'b00;
    logic                      busError;
    logic                      instValid;
    logic                      instReady = 1'b0;
    logic [fetchAddrWidth-1:0] instPc;
    logic [5:0]                instCmd;
    logic [3:0]                instMode;
    logic [15:0]               instOperand;

    logic [7:0]  mem [256];
    logic [31:0] lfsr      = 32'h50a4;
    logic [1:0]  subState  = 2'd0; // idle, ar delay, ar taken, r delay
    logic [1:0]  delayLeft = 2'd0;
    logic [7:0]  reqAddr   = 8'h00;
    int          accepted  = 0;
    int          cycleCount = 0;
    int          otherErrs = 0;
    int          assertErrs;
    int          waitCycles;

    instructionPredecoder instructionPredecoder_inst (.*);

    always #10 clk = ~clk;

    function automatic logic [7:0] drawBits(input int n);
        logic       fb;
        logic [7:0] bits;
        bits = 8'h00;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[6:0], fb};
        end
        return bits;
    endfunction

    task automatic loadProgram();
        for (int a = 0; a < 256; a++) mem[a] = 8'(a * 37) ^ 8'h5a; // every address bit matters
        for (int i = 0; i < 13; i++) mem[i] = directed[i];
    endtask

    task automatic pulseStart(input logic [15:0] pc);
        @(negedge clk);
        start   = 1'b1;
        startPc = pc;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic runFrom(input logic [15:0] pc, input int count);
        int target;
        pulseStart(pc);
        target = accepted + count;
        while (accepted < target) @(negedge clk);
    endtask

    // AXI4-Lite read subordinate and random instReady on the falling edge
    always @(negedge clk) begin
        logic [7:0] r;
        r         = drawBits(1);
        instReady = r[0];
        rValid    = 1'b0; // one-cycle response since rReady is already high
        case (subState)
            2'd0: begin
                if (arValid) begin
                    r         = drawBits(2);
                    delayLeft = r[1:0]; // cycles before arReady
                    subState  = 2'd1;
                end
            end
            2'd1: begin
                if (delayLeft == 2'd0) begin
                    arReady  = 1'b1;
                    reqAddr  = arAddr[7:0];
                    subState = 2'd2;
                end else begin
                    delayLeft = delayLeft - 2'd1;
                end
            end
            2'd2: begin
                arReady   = 1'b0;
                r         = drawBits(2);
                delayLeft = r[1:0];
                subState  = 2'd3;
            end
            default: begin
                if (delayLeft == 2'd0) begin
                    rValid   = 1'b1;
                    rData    = {mem[reqAddr + 8'd3], mem[reqAddr + 8'd2],
                                mem[reqAddr + 8'd1], mem[reqAddr]};
                    rResp    = (reqAddr == errWord) ? 2'b10 : 2'b00;
                    subState = 2'd0;
                end else begin
                    delayLeft = delayLeft - 2'd1;
                end
            end
        endcase
    end

    always @(posedge clk) begin
        if (instValid && instReady && !start) accepted <= accepted + 1;
    end

    initial begin
        while (cycleCount < cycleLimit) @(posedge clk) cycleCount++;
        $display("ERROR: timeout after %0d cycles without finishing", cycleCount);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        arstN   = 1'b1;
        start   = 1'b0;
        startPc = 16'h0000;
        loadProgram();
        #1 arstN = 1'b0; // clean falling edge for the async reset
        repeat (3) @(negedge clk);
        arstN = 1'b1;
        runFrom(16'h0000, instPerRun); // directed opcodes
        runFrom(16'h0041, instPerRun); // unaligned start
        pulseStart(16'h00e2);          // runs into the marked word
        waitCycles = 0;
        while (!busError && waitCycles < 400) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!busError) begin
            otherErrs++;
            $display("ERROR: busError never set after the marked word was read");
        end
        repeat (8) @(negedge clk);     // fetch should stay idle here
        runFrom(16'h0023, instPerRun);
        assertErrs = instructionPredecoder_inst.predecoderAssertions_inst.errCount;
        $display("error counts: %0d assertion failures, %0d other errors",
                 assertErrs, otherErrs);
        if (assertErrs + otherErrs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
verilog/predecoderPkg.sv
verilog/decoder.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/operandStage.sv
verilog/instructionPredecoder.sv
tb/predecoder_assertions.sv
tb/predecoderTb.sv

// ==== Makefile ====
# Verilator build and run for the instruction predecoder testbench

TOP       ?= predecoderTb
FLIST     ?= project.f
LOG       ?= sim.log
OBJDIR    ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
SIMARGS   ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run $(TOP), pass if $(LOG) holds the pass line"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	./$(OBJDIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1; true
	@cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
